// File: filelist.f
ofc_pkg.sv
tag_rewriter.sv
word_buffer.sv
byte_counter.sv
tx_fsm.sv
byte_serializer.sv
frame_tx_top.sv
tx_checker.sv
tb_frame_tx.sv

// File: run_sim.sh
#!/bin/sh
# build and run the frame transmit testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
    --top-module tb_frame_tx -f filelist.f -o sim_frame_tx > build.log 2>&1 \
    && ./obj_dir/sim_frame_tx > sim.log 2>&1 \
    || echo "build or run step returned an error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "Simulation passed" sim.log 2>/dev/null && exit 0 || exit 1

// File: tb_frame_tx.sv
////////////////////////////////////////
// testbench top for the frame transmit path
// clock, reset, frame table, word source
// random payload and run timeout
////////////////////////////////////////

`timescale 1ns/10ps

module tb_frame_tx;

    import ofc_pkg::*;

    localparam int N_FRAMES = 6;

    typedef struct packed {
        tag_t        tag;
        logic        match;     // address already equals the tag
        logic [15:0] etype;
        logic [3:0]  nwords;
        pad_t        pad;
        logic [7:0]  idle;      // source idle cycles between words
    } frame_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        desc_valid;
    tag_t        desc_tag;
    logic        word_valid;
    word_t       word_data;
    logic        word_first;
    logic        word_last;
    pad_t        word_pad;
    logic        word_ready;
    logic        tx_en;
    byte_t       tx_data;
    logic        tx_last;
    int          value_errs;
    int          other_errs;
    int          frames_done;
    int          pending;
    int          end_errs      = 0;
    int          timeout_limit = 0;
    int          cycle_cnt     = 0;
    frame_t      frames [N_FRAMES];
    logic [15:0] lfsr_state    = 16'd57;

    always #20 clk = ~clk;

    frame_tx_top UUT (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_desc_valid (desc_valid),
        .i_desc_tag   (desc_tag),
        .i_word_valid (word_valid),
        .i_word_data  (word_data),
        .i_word_first (word_first),
        .i_word_last  (word_last),
        .i_word_pad   (word_pad),
        .o_word_ready (word_ready),
        .o_tx_en      (tx_en),
        .o_tx_data    (tx_data),
        .o_tx_last    (tx_last)
    );

    tx_checker u_checker (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_desc_valid  (desc_valid),
        .i_desc_tag    (desc_tag),
        .i_word_valid  (word_valid),
        .i_word_data   (word_data),
        .i_word_first  (word_first),
        .i_word_last   (word_last),
        .i_word_pad    (word_pad),
        .i_word_ready  (word_ready),
        .i_tx_en       (tx_en),
        .i_tx_data     (tx_data),
        .i_tx_last     (tx_last),
        .o_value_errs  (value_errs),
        .o_other_errs  (other_errs),
        .o_frames_done (frames_done),
        .o_pending     (pending)
    );

    // galois lfsr for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_word(output word_t w);
        for (int i = 0; i < WORD_W; i++) begin
            w[i]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // preamble, payload and gap of every frame plus source idle time with 50 percent margin
    function automatic int calc_limit();
        int total;
        total = 0;
        for (int f = 0; f < N_FRAMES; f++) begin
            total += PREAMBLE_LEN + BYTES_PER_WORD * int'(frames[f].nwords) + GAP_CYCLES
                   + int'(frames[f].idle) * (int'(frames[f].nwords) - 1);
        end
        return total + total / 2;
    endfunction

    ////////////////////////////////////////
    // word source driven on the falling edge
    ////////////////////////////////////////
    task automatic offer_word(input word_t data, input logic first, input logic last,
                              input pad_t pad);
        logic taken;
        word_valid = 1'b1;
        word_data  = data;
        word_first = first;
        word_last  = last;
        word_pad   = last ? pad : 4'd0;
        do begin
            taken = word_ready;     // ready only moves on the rising edge
            @(negedge clk);
        end while (!taken);
        word_valid = 1'b0;
    endtask

    task automatic send_frame(input frame_t fr);
        word_t data;
        desc_valid = 1'b1;
        desc_tag   = fr.tag;
        @(negedge clk);
        desc_valid = 1'b0;
        for (int w = 0; w < int'(fr.nwords); w++) begin
            rand_word(data);
            if (w == 0) begin
                if (fr.match) begin
                    data[TAG_MSB:TAG_LSB] = fr.tag;
                end else if (data[TAG_MSB:TAG_LSB] == fr.tag) begin
                    data[TAG_LSB] = ~data[TAG_LSB];
                end
                data[ETYPE_MSB:ETYPE_LSB] = fr.etype;
            end
            offer_word(data, w == 0, w == int'(fr.nwords) - 1, fr.pad);
            if (w < int'(fr.nwords) - 1) begin
                repeat (int'(fr.idle)) @(negedge clk);
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_limit) begin
            $display("timeout after %0d cycles, the transmit path hung", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst_n      = 1'b0;
        desc_valid = 1'b0;
        desc_tag   = '0;
        word_valid = 1'b0;
        word_data  = '0;
        word_first = 1'b0;
        word_last  = 1'b0;
        word_pad   = '0;

        // ipv4 with foreign address gets rewritten
        frames[0] = '{tag: 48'h0A1B2C3D4E5F, match: 1'b0, etype: 16'h0800,
                      nwords: 4'd3, pad: 4'd0, idle: 8'd0};
        frames[1] = '{tag: 48'h112233445566, match: 1'b1, etype: 16'h0800,
                      nwords: 4'd2, pad: 4'd5, idle: 8'd0};
        // slow source leaves the line waiting for the second word
        frames[2] = '{tag: 48'h00A0C9E1F203, match: 1'b0, etype: 16'h86DD,
                      nwords: 4'd2, pad: 4'd15, idle: 8'd60};
        frames[3] = '{tag: 48'h3C4D5E6F7081, match: 1'b0, etype: 16'h0800,
                      nwords: 4'd1, pad: 4'd3, idle: 8'd0};
        frames[4] = '{tag: 48'h665544332211, match: 1'b1, etype: 16'h88F7,
                      nwords: 4'd4, pad: 4'd8, idle: 8'd0};
        frames[5] = '{tag: 48'h7E8F90A1B2C3, match: 1'b0, etype: 16'h0800,
                      nwords: 4'd2, pad: 4'd1, idle: 8'd17};
        timeout_limit = calc_limit();

        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        for (int f = 0; f < N_FRAMES; f++) begin
            send_frame(frames[f]);
        end
        while (frames_done < N_FRAMES) @(negedge clk);
        repeat (GAP_CYCLES + 4) @(negedge clk);     // line must stay quiet
        if (pending != 0) begin
            end_errs++;
            $display("%0d predicted bytes never appeared on the line", pending);
        end
        $display("error counts: %0d value, %0d other, %0d at end of run",
                 value_errs, other_errs, end_errs);
        if (value_errs + other_errs + end_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tx_checker.sv
////////////////////////////////////////
// checker for the frame transmit path
// predicts the byte stream from accepted words
// checks bytes, last flag, gap and word ready
////////////////////////////////////////

`timescale 1ns/10ps

module tx_checker (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_desc_valid,
    input  ofc_pkg::tag_t  i_desc_tag,
    input  logic           i_word_valid,
    input  ofc_pkg::word_t i_word_data,
    input  logic           i_word_first,
    input  logic           i_word_last,
    input  ofc_pkg::pad_t  i_word_pad,
    input  logic           i_word_ready,
    input  logic           i_tx_en,
    input  ofc_pkg::byte_t i_tx_data,
    input  logic           i_tx_last,
    output int             o_value_errs,
    output int             o_other_errs,
    output int             o_frames_done,
    output int             o_pending
);

    import ofc_pkg::*;

    typedef struct packed {
        byte_t      data;
        logic       last;
        logic       word_end;   // final valid byte of a word
        logic [1:0] kind;       // preamble, sfd, header word, payload
    } exp_t;

    exp_t exp_q [$];
    tag_t tag_q       = '0;
    int   value_errs  = 0;
    int   other_errs  = 0;
    int   frames_done = 0;
    int   pending     = 0;
    int   words_acc   = 0;
    int   words_done  = 0;
    int   frame_pos   = 0;      // bytes of the current frame seen so far
    int   gap_len     = 0;
    logic gap_active  = 1'b0;
    logic gap_exact   = 1'b0;   // next frame already queued at the last byte

    assign o_value_errs  = value_errs;
    assign o_other_errs  = other_errs;
    assign o_frames_done = frames_done;
    assign o_pending     = pending;

    function automatic string kind_name(input logic [1:0] k);
        case (k)
            2'd0:    return "preamble";
            2'd1:    return "sfd";
            2'd2:    return "header word";
            default: return "payload";
        endcase
    endfunction

    task automatic push_byte(input byte_t d, input logic l, input logic we, input logic [1:0] k);
        exp_t e;
        e.data     = d;
        e.last     = l;
        e.word_end = we;
        e.kind     = k;
        exp_q.push_back(e);
    endtask

    ////////////////////////////////////////
    // expected bytes of one accepted word
    ////////////////////////////////////////
    task automatic take_word();
        word_t w;
        int    n;
        w = i_word_data;
        if (i_word_first) begin
            for (int i = 0; i < PREAMBLE_LEN - 1; i++) begin
                push_byte(PREAMBLE_BYTE, 1'b0, 1'b0, 2'd0);
            end
            push_byte(SFD_BYTE, 1'b0, 1'b0, 2'd1);
            // ipv4 frames with a foreign address get the tsn ethertype
            if (w[TAG_MSB:TAG_LSB] != tag_q && w[ETYPE_MSB:ETYPE_LSB] == ETYPE_IPV4) begin
                w[ETYPE_MSB:ETYPE_LSB] = ETYPE_TSN;
            end
            w[TAG_MSB:TAG_LSB] = tag_q;
        end
        n = i_word_last ? BYTES_PER_WORD - int'(i_word_pad) : BYTES_PER_WORD;
        for (int i = 0; i < n; i++) begin
            push_byte(w[WORD_W-1-8*i -: 8], i_word_last && (i == n - 1), i == n - 1,
                      i_word_first ? 2'd2 : 2'd3);
        end
        words_acc++;
    endtask

    task automatic check_byte();
        exp_t e;
        if (!i_tx_en) begin
            if (i_tx_last) begin
                other_errs++;
                $display("last flag raised while the line is idle");
            end
            if (frame_pos > 0 && frame_pos < PREAMBLE_LEN) begin
                other_errs++;
                $display("preamble broken by an idle cycle in frame %0d", frames_done);
            end
            if (gap_active) gap_len++;
        end else if (exp_q.size() == 0) begin
            other_errs++;
            $display("byte %h sent with no accepted word behind it", i_tx_data);
        end else begin
            e = exp_q.pop_front();
            if (gap_active && (gap_len < GAP_CYCLES || (gap_exact && gap_len != GAP_CYCLES))) begin
                value_errs++;
                $display("ERROR interframe gap: expected %0d actual %0d", GAP_CYCLES, gap_len);
            end
            gap_active = 1'b0;
            if (i_tx_data !== e.data) begin
                value_errs++;
                $display("ERROR %s (frame %0d, byte %0d): expected %h actual %h",
                         kind_name(e.kind), frames_done, frame_pos, e.data, i_tx_data);
            end
            if (i_tx_last !== e.last) begin
                value_errs++;
                $display("ERROR last flag (frame %0d, byte %0d): expected %b actual %b",
                         frames_done, frame_pos, e.last, i_tx_last);
            end
            frame_pos++;
            if (e.word_end) words_done++;
            if (e.last) begin
                frames_done++;
                frame_pos  = 0;
                gap_active = 1'b1;
                gap_len    = 0;
                gap_exact  = exp_q.size() != 0;
            end
        end
    endtask

    // ready is low exactly while both buffer entries hold unsent words
    task automatic check_ready();
        logic exp_ready;
        exp_ready = (words_acc - words_done) < 2;
        if (i_word_ready !== exp_ready) begin
            value_errs++;
            $display("ERROR word ready: expected %b actual %b", exp_ready, i_word_ready);
        end
    endtask

    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            if (i_tx_en || i_tx_last || i_tx_data != 8'h00 || !i_word_ready) begin
                other_errs++;
                $display("outputs not in their reset state while reset is held");
            end
        end else begin
            check_byte();
            check_ready();
            if (i_word_valid && i_word_ready) take_word();
            if (i_desc_valid) tag_q = i_desc_tag;   // same edge as the tag register
            pending = exp_q.size();
        end
    end

endmodule

// File: frame_tx_top.sv
////////////////////////////////////////
// frame transmit top level
// tag rewrite, word buffer, FSM, counter, serializer
////////////////////////////////////////

`timescale 1ns/10ps

module frame_tx_top (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_desc_valid,
    input  ofc_pkg::tag_t  i_desc_tag,
    input  logic           i_word_valid,
    input  ofc_pkg::word_t i_word_data,
    input  logic           i_word_first,
    input  logic           i_word_last,
    input  ofc_pkg::pad_t  i_word_pad,
    output logic           o_word_ready,
    output logic           o_tx_en,
    output ofc_pkg::byte_t o_tx_data,
    output logic           o_tx_last
);

    import ofc_pkg::*;

    word_t     rw_data;     // word after the header rewrite
    logic      head_valid;
    word_t     head_data;
    logic      head_first;
    logic      head_last;
    pad_t      head_pad;
    logic      pop;
    logic      cnt_clear;
    logic      cnt_inc;
    cnt_t      count;
    logic      emit;
    byte_sel_t sel;
    logic      last;

    tag_rewriter u_tag_rewriter (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_desc_valid (i_desc_valid),
        .i_desc_tag   (i_desc_tag),
        .i_word_valid (i_word_valid),
        .i_word_data  (i_word_data),
        .i_word_first (i_word_first),
        .o_word_data  (rw_data)
    );

    word_buffer u_word_buffer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_word_valid (i_word_valid),
        .i_word_data  (rw_data),
        .i_word_first (i_word_first),
        .i_word_last  (i_word_last),
        .i_word_pad   (i_word_pad),
        .i_pop        (pop),
        .o_word_ready (o_word_ready),
        .o_head_valid (head_valid),
        .o_head_data  (head_data),
        .o_head_first (head_first),
        .o_head_last  (head_last),
        .o_head_pad   (head_pad)
    );

    byte_counter u_byte_counter (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_clear (cnt_clear),
        .i_inc   (cnt_inc),
        .o_count (count)
    );

    tx_fsm u_tx_fsm (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_head_valid (head_valid),
        .i_head_first (head_first),
        .i_head_last  (head_last),
        .i_head_pad   (head_pad),
        .i_count      (count),
        .o_pop        (pop),
        .o_cnt_clear  (cnt_clear),
        .o_cnt_inc    (cnt_inc),
        .o_emit       (emit),
        .o_sel        (sel),
        .o_last       (last)
    );

    byte_serializer u_byte_serializer (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_emit      (emit),
        .i_sel       (sel),
        .i_last      (last),
        .i_head_data (head_data),
        .i_count     (count),
        .o_tx_en     (o_tx_en),
        .o_tx_data   (o_tx_data),
        .o_tx_last   (o_tx_last)
    );

endmodule

// File: byte_serializer.sv
////////////////////////////////////////
// output byte select and GMII-style
// registered enable, data and last
////////////////////////////////////////

`timescale 1ns/10ps

module byte_serializer (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_emit,
    input  ofc_pkg::byte_sel_t i_sel,
    input  logic               i_last,
    input  ofc_pkg::word_t     i_head_data,
    input  ofc_pkg::cnt_t      i_count,
    output logic               o_tx_en,
    output ofc_pkg::byte_t     o_tx_data,
    output logic               o_tx_last
);

    import ofc_pkg::*;

    cnt_t  byte_idx;    // msb first, byte 0 sits at the top of the word
    byte_t data_byte;
    byte_t next_byte;

    assign byte_idx  = cnt_t'(BYTES_PER_WORD - 1) - i_count;
    assign data_byte = i_head_data[byte_idx * $bits(byte_t) +: $bits(byte_t)];

    always_comb begin
        case (i_sel)
            SEL_PREAMBLE: next_byte = PREAMBLE_BYTE;
            SEL_SFD:      next_byte = SFD_BYTE;
            default:      next_byte = data_byte;
        endcase
    end

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_tx_en   <= 1'b0;
            o_tx_data <= '0;
            o_tx_last <= 1'b0;
        end else begin
            o_tx_en   <= i_emit;
            o_tx_last <= i_emit & i_last;
            if (i_emit) begin
                o_tx_data <= next_byte;     // held while idle
            end
        end
    end

endmodule

// File: tx_fsm.sv
////////////////////////////////////////
// transmit FSM
// preamble, payload and gap sequencing
// word pops and counter control
////////////////////////////////////////

`timescale 1ns/10ps

module tx_fsm (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_head_valid,
    input  logic               i_head_first,
    input  logic               i_head_last,
    input  ofc_pkg::pad_t      i_head_pad,
    input  ofc_pkg::cnt_t      i_count,
    output logic               o_pop,
    output logic               o_cnt_clear,
    output logic               o_cnt_inc,
    output logic               o_emit,
    output ofc_pkg::byte_sel_t o_sel,
    output logic               o_last
);

    import ofc_pkg::*;

    tx_state_t state_q;
    tx_state_t state_d;
    cnt_t      last_idx;    // index of the final valid byte in the head word
    logic      data_cycle;  // a payload byte goes out this cycle

    assign last_idx = i_head_last ? cnt_t'(BYTES_PER_WORD - 1) - i_head_pad
                                  : cnt_t'(BYTES_PER_WORD - 1);

    // word boundary state also sends byte 0 once the head fills
    assign data_cycle = (state_q == ST_PAYLOAD) ||
                        (state_q == ST_WAIT_WORD && i_head_valid);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////////////////////////
    // next state and outputs
    ////////////////////////////////////////
    always_comb begin
        state_d     = state_q;
        o_pop       = 1'b0;
        o_cnt_clear = 1'b0;
        o_cnt_inc   = 1'b0;
        o_emit      = 1'b0;
        o_sel       = SEL_DATA;
        o_last      = 1'b0;

        case (state_q)
            ST_IDLE: begin
                o_cnt_clear = 1'b1;
                if (i_head_valid && i_head_first) begin
                    state_d = ST_PREAMBLE;
                end
            end

            ST_PREAMBLE: begin
                o_emit = 1'b1;
                if (i_count == cnt_t'(PREAMBLE_LEN - 1)) begin
                    o_sel       = SEL_SFD;
                    o_cnt_clear = 1'b1;
                    state_d     = i_head_valid ? ST_PAYLOAD : ST_WAIT_WORD;
                end else begin
                    o_sel     = SEL_PREAMBLE;
                    o_cnt_inc = 1'b1;
                end
            end

            ST_PAYLOAD, ST_WAIT_WORD: begin
                if (data_cycle) begin
                    o_emit = 1'b1;
                    if (i_count == last_idx) begin
                        o_pop       = 1'b1;     // word done, release the entry
                        o_cnt_clear = 1'b1;
                        if (i_head_last) begin
                            o_last  = 1'b1;
                            state_d = ST_GAP;
                        end else begin
                            state_d = ST_WAIT_WORD;
                        end
                    end else begin
                        o_cnt_inc = 1'b1;
                        state_d   = ST_PAYLOAD;
                    end
                end
            end

            ST_GAP: begin
                // the idle cycle before the next preamble completes the gap
                if (i_count == cnt_t'(GAP_CYCLES - 2)) begin
                    o_cnt_clear = 1'b1;
                    state_d     = ST_IDLE;
                end else begin
                    o_cnt_inc = 1'b1;
                end
            end

            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // buffer must keep the word at the head until it is popped
    a_payload_has_head: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (state_q == ST_PAYLOAD) |-> i_head_valid
    );

endmodule

// File: byte_counter.sv
////////////////////////////////////////
// shared timer for preamble, byte index and gap
////////////////////////////////////////

`timescale 1ns/10ps

module byte_counter (
    input  logic          i_clk,
    input  logic          i_rst_n,
    input  logic          i_clear,
    input  logic          i_inc,
    output ofc_pkg::cnt_t o_count
);

    // clear wins over increment
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_count <= '0;
        end else if (i_clear) begin
            o_count <= '0;
        end else if (i_inc) begin
            o_count <= o_count + 1'b1;
        end
    end

endmodule

// File: word_buffer.sv
////////////////////////////////////////
// two-entry ping-pong word store
// valid/ready write side, pop from the reader
////////////////////////////////////////

`timescale 1ns/10ps

module word_buffer (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_word_valid,
    input  ofc_pkg::word_t i_word_data,
    input  logic           i_word_first,
    input  logic           i_word_last,
    input  ofc_pkg::pad_t  i_word_pad,
    input  logic           i_pop,
    output logic           o_word_ready,
    output logic           o_head_valid,
    output ofc_pkg::word_t o_head_data,
    output logic           o_head_first,
    output logic           o_head_last,
    output ofc_pkg::pad_t  o_head_pad
);

    import ofc_pkg::*;

    word_t      data_q [2];
    pad_t       pad_q  [2];
    logic [1:0] first_q;
    logic [1:0] last_q;
    logic [1:0] vld_q;      // entry occupied
    logic       wr_ptr;     // next entry to fill
    logic       rd_ptr;     // entry presented at the head
    logic       wr_en;

    assign o_word_ready = ~(vld_q[0] & vld_q[1]);
    assign wr_en        = i_word_valid & o_word_ready;

    ////////////////////////////////////////
    // occupancy and pointers
    ////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vld_q  <= '0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else begin
            // write and pop always hit different entries
            if (wr_en) begin
                vld_q[wr_ptr] <= 1'b1;
                wr_ptr        <= ~wr_ptr;
            end
            if (i_pop) begin
                vld_q[rd_ptr] <= 1'b0;
                rd_ptr        <= ~rd_ptr;
            end
        end
    end

    // payload storage
    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            data_q[wr_ptr]  <= i_word_data;
            pad_q[wr_ptr]   <= i_word_pad;
            first_q[wr_ptr] <= i_word_first;
            last_q[wr_ptr]  <= i_word_last;
        end
    end

    assign o_head_valid = vld_q[rd_ptr];
    assign o_head_data  = data_q[rd_ptr];
    assign o_head_first = first_q[rd_ptr];
    assign o_head_last  = last_q[rd_ptr];
    assign o_head_pad   = pad_q[rd_ptr];

    // the reader releases only what it has been shown
    a_pop_needs_head: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_pop |-> o_head_valid
    );

    // an accepted word never lands on an occupied entry
    a_write_to_free: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        wr_en |-> !vld_q[wr_ptr]
    );

endmodule

// File: tag_rewriter.sv
////////////////////////////////////////
// descriptor tag cache
// first-word address and ethertype rewrite
////////////////////////////////////////

`timescale 1ns/10ps

module tag_rewriter (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_desc_valid,
    input  ofc_pkg::tag_t  i_desc_tag,
    input  logic           i_word_valid,
    input  ofc_pkg::word_t i_word_data,
    input  logic           i_word_first,
    output ofc_pkg::word_t o_word_data
);

    import ofc_pkg::*;

    tag_t tag_q;        // last tag seen on the descriptor strobe
    logic addr_differs;
    logic is_ipv4;

    // descriptor strobe has no handshake, capture every time
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tag_q <= '0;
        end else if (i_desc_valid) begin
            tag_q <= i_desc_tag;
        end
    end

    assign addr_differs = (i_word_data[TAG_MSB:TAG_LSB] != tag_q);
    assign is_ipv4      = (i_word_data[ETYPE_MSB:ETYPE_LSB] == ETYPE_IPV4);

    // only the first word of a frame carries the header fields
    always_comb begin
        o_word_data = i_word_data;
        if (i_word_valid && i_word_first) begin
            o_word_data[TAG_MSB:TAG_LSB] = tag_q;
            if (addr_differs && is_ipv4) begin
                o_word_data[ETYPE_MSB:ETYPE_LSB] = ETYPE_TSN;   // mark as tsn frame
            end
        end
    end

endmodule

// File: ofc_pkg.sv
////////////////////////////////////////
// shared widths, field positions and constants
// typedefs for word, byte, tag, pad and counter
// enums for the transmit FSM and the byte select
////////////////////////////////////////

package ofc_pkg;

    // packet word
    localparam int WORD_W         = 128;
    localparam int BYTES_PER_WORD = 16;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [7:0]        byte_t;
    typedef logic [3:0]        pad_t;    // invalid trailing bytes of a last word
    typedef logic [3:0]        cnt_t;    // shared timer value

    // destination-address field, overwritten by the tsn tag
    localparam int TAG_MSB = 127;
    localparam int TAG_LSB = 80;

    typedef logic [TAG_MSB-TAG_LSB:0] tag_t;

    // ethertype field of the first word
    localparam int ETYPE_MSB = 31;
    localparam int ETYPE_LSB = 16;

    localparam logic [15:0] ETYPE_IPV4 = 16'h0800;
    localparam logic [15:0] ETYPE_TSN  = 16'h1800;

    ////////////////////////////////////////
    // line framing
    ////////////////////////////////////////
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;
    localparam int    PREAMBLE_LEN  = 8;     // seven preamble bytes plus sfd
    localparam int    GAP_CYCLES    = 12;    // idle cycles between frames

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_PAYLOAD,
        ST_WAIT_WORD,
        ST_GAP
    } tx_state_t;

    typedef enum logic [1:0] {
        SEL_PREAMBLE,
        SEL_SFD,
        SEL_DATA
    } byte_sel_t;

endpackage
